//--- verilog/nice_pkg.sv
// NICE coprocessor shared definitions

package nice_pkg;

  ////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////

  // one word of data or address
  parameter int xlen = 32;

  // words per row unless the top level overrides it
  parameter int row_len_dflt = 3;

  // row buffer depth, must cover the row length
  parameter int rowbuf_dp    = 4;
  parameter int rowbuf_idx_w = 2;

  ////////////////////////////////////////
  // instruction encodings
  ////////////////////////////////////////

  // custom-3 major opcode, R type only
  parameter logic [6:0] opcode_custom3 = 7'b1111011;

  // lbuf and sbuf share funct3
  parameter logic [2:0] funct3_buf    = 3'b010;
  parameter logic [2:0] funct3_rowsum = 3'b110;

  parameter logic [6:0] funct7_lbuf   = 7'd1;
  parameter logic [6:0] funct7_sbuf   = 7'd2;
  parameter logic [6:0] funct7_rowsum = 7'd6;

  ////////////////////////////////////////
  // memory access
  ////////////////////////////////////////

  // byte step between consecutive words
  parameter int word_stride = 4;

  // ICB size code for a 32-bit access
  parameter logic [1:0] icb_size_word = 2'b10;

  // operation carried from decode down to the beat consumers
  typedef enum logic [1:0] {
    op_none   = 2'd0,
    op_lbuf   = 2'd1,
    op_sbuf   = 2'd2,
    op_rowsum = 2'd3
  } nice_op_e;

endpackage

//--- verilog/nice_beat_if.sv
// Memory response beat stream

interface nice_beat_if #(
  parameter int XLEN = nice_pkg::xlen
) ();

  // one pulse per ICB response, consumers never stall
  logic                              valid;
  // operation of the job the beat belongs to
  nice_pkg::nice_op_e                op;
  // word position in the row, counted in response order
  logic [nice_pkg::rowbuf_idx_w-1:0] idx;
  // read data straight from the ICB response
  logic [XLEN-1:0]                   data;
  logic                              err;

  // driven by the memory agent
  modport src (
    output valid, op, idx, data, err
  );

  // row buffer and rowsum accumulator
  modport sink (
    input valid, op, idx, data, err
  );

endinterface

//--- verilog/nice_ctrl.sv
// NICE instruction control

module nice_ctrl #(
  parameter int XLEN    = nice_pkg::xlen,
  parameter int ROW_LEN = nice_pkg::row_len_dflt
) (
  input  logic               nice_clk,
  input  logic               nice_rst_n,
  // host request
  input  logic               req_valid,
  output logic               req_ready,
  input  logic [XLEN-1:0]    req_inst,
  input  logic [XLEN-1:0]    req_rs1,
  // host response
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output logic [XLEN-1:0]    rsp_rdat,
  output logic               rsp_err,
  // core status
  output logic               active,
  output logic               mem_holdup,
  // job handoff to the memory agent
  output logic               job_start,
  output nice_pkg::nice_op_e job_op,
  output logic [XLEN-1:0]    job_base,
  input  logic               job_done,
  input  logic               job_err,
  // rowsum result
  input  logic [XLEN-1:0]    rowsum_sum
);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_resp
  } state_e;

  state_e             state;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  nice_pkg::nice_op_e dec_op;
  nice_pkg::nice_op_e op_q;
  logic               err_q;
  logic               req_hsk;
  logic               rsp_hsk;

  // row must be at least one word
  if (ROW_LEN < 1) begin : g_row_len_chk
    $error("nice_ctrl: ROW_LEN must be at least 1");
  end

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  assign opcode = req_inst[6:0];
  assign funct3 = req_inst[14:12];
  assign funct7 = req_inst[31:25];

  always_comb begin
    dec_op = nice_pkg::op_none;
    if (opcode == nice_pkg::opcode_custom3) begin
      if (funct3 == nice_pkg::funct3_buf && funct7 == nice_pkg::funct7_lbuf)
        dec_op = nice_pkg::op_lbuf;
      else if (funct3 == nice_pkg::funct3_buf && funct7 == nice_pkg::funct7_sbuf)
        dec_op = nice_pkg::op_sbuf;
      else if (funct3 == nice_pkg::funct3_rowsum && funct7 == nice_pkg::funct7_rowsum)
        dec_op = nice_pkg::op_rowsum;
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////
  assign req_hsk = req_valid & req_ready;
  assign rsp_hsk = rsp_valid & rsp_ready;

  // unknown instructions are taken and dropped, state stays idle
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      state <= st_idle;
      op_q  <= nice_pkg::op_none;
    end else begin
      case (state)
        st_idle: begin
          if (req_hsk && dec_op != nice_pkg::op_none) begin
            state <= st_busy;
            op_q  <= dec_op;
          end
        end
        st_busy: begin
          if (job_done)
            state <= st_resp;
        end
        st_resp: begin
          if (rsp_hsk)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // error of the finished job, held through the response
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      err_q <= 1'b0;
    end else if (state == st_busy && job_done) begin
      err_q <= job_err;
    end
  end

  // job leaves on the accepting cycle so the first command follows next cycle
  assign job_start = req_hsk & (dec_op != nice_pkg::op_none);
  assign job_op    = dec_op;
  assign job_base  = req_rs1;

  ////////////////////////////////////////
  // host side outputs
  ////////////////////////////////////////
  assign req_ready  = (state == st_idle);
  assign rsp_valid  = (state == st_resp);
  // sum settles on the edge that enters st_resp
  assign rsp_rdat   = (op_q == nice_pkg::op_rowsum) ? rowsum_sum : '0;
  assign rsp_err    = err_q;
  assign mem_holdup = (state != st_idle);
  assign active     = (state == st_idle) ? req_valid : 1'b1;

endmodule

//--- verilog/nice_mem_agent.sv
// NICE memory agent

module nice_mem_agent #(
  parameter int XLEN    = nice_pkg::xlen,
  parameter int ROW_LEN = nice_pkg::row_len_dflt
) (
  input  logic                              nice_clk,
  input  logic                              nice_rst_n,
  // job handoff
  input  logic                              job_start,
  input  nice_pkg::nice_op_e                job_op,
  input  logic [XLEN-1:0]                   job_base,
  output logic                              job_done,
  output logic                              job_err,
  // ICB command
  output logic                              icb_cmd_valid,
  input  logic                              icb_cmd_ready,
  output logic [XLEN-1:0]                   icb_cmd_addr,
  output logic                              icb_cmd_read,
  output logic [XLEN-1:0]                   icb_cmd_wdata,
  output logic [1:0]                        icb_cmd_size,
  // ICB response
  input  logic                              icb_rsp_valid,
  output logic                              icb_rsp_ready,
  input  logic [XLEN-1:0]                   icb_rsp_rdata,
  input  logic                              icb_rsp_err,
  // row buffer read port for sbuf
  output logic [nice_pkg::rowbuf_idx_w-1:0] rd_idx,
  input  logic [XLEN-1:0]                   rd_data,
  // beat stream to the consumers
  nice_beat_if.src                          beat
);

  // one extra bit so the counters can reach ROW_LEN
  localparam int cnt_w = nice_pkg::rowbuf_idx_w + 1;

  logic               busy;
  logic               cmd_valid_q;
  nice_pkg::nice_op_e op_q;
  logic [XLEN-1:0]    addr_q;
  logic [cnt_w-1:0]   cmd_cnt;
  logic [cnt_w-1:0]   rsp_cnt;
  logic               err_q;
  logic               cmd_hsk;
  logic               rsp_hsk;
  logic               rsp_last;

  assign cmd_hsk  = icb_cmd_valid & icb_cmd_ready;
  // responses outside a job are not ours
  assign rsp_hsk  = icb_rsp_valid & busy;
  assign rsp_last = rsp_hsk & (rsp_cnt == cnt_w'(ROW_LEN - 1));

  ////////////////////////////////////////
  // command side
  ////////////////////////////////////////
  // address steps one word per accepted command
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      cmd_valid_q <= 1'b0;
      op_q        <= nice_pkg::op_none;
      addr_q      <= '0;
      cmd_cnt     <= '0;
    end else if (job_start) begin
      cmd_valid_q <= 1'b1;
      op_q        <= job_op;
      addr_q      <= job_base;
      cmd_cnt     <= '0;
    end else if (cmd_hsk) begin
      addr_q  <= addr_q + XLEN'(nice_pkg::word_stride);
      cmd_cnt <= cmd_cnt + 1'b1;
      // stop once the last word of the row is taken
      if (cmd_cnt == cnt_w'(ROW_LEN - 1))
        cmd_valid_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////
  // counted apart from commands, several may be in flight
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      busy    <= 1'b0;
      rsp_cnt <= '0;
      err_q   <= 1'b0;
    end else if (job_start) begin
      busy    <= 1'b1;
      rsp_cnt <= '0;
      err_q   <= 1'b0;
    end else if (rsp_hsk) begin
      rsp_cnt <= rsp_cnt + 1'b1;
      err_q   <= err_q | icb_rsp_err;
      if (rsp_last)
        busy <= 1'b0;
    end
  end

  // done rides on the last beat itself
  assign job_done = rsp_last;
  assign job_err  = err_q | icb_rsp_err;

  // sbuf data comes from the word the next command addresses
  assign rd_idx = cmd_cnt[nice_pkg::rowbuf_idx_w-1:0];

  assign icb_cmd_valid = cmd_valid_q;
  assign icb_cmd_addr  = addr_q;
  assign icb_cmd_read  = (op_q != nice_pkg::op_sbuf);
  assign icb_cmd_wdata = rd_data;
  assign icb_cmd_size  = nice_pkg::icb_size_word;
  assign icb_rsp_ready = 1'b1;

  // beat stream, same cycle as the response
  assign beat.valid = rsp_hsk;
  assign beat.op    = op_q;
  assign beat.idx   = rsp_cnt[nice_pkg::rowbuf_idx_w-1:0];
  assign beat.data  = icb_rsp_rdata;
  assign beat.err   = icb_rsp_err;

endmodule

//--- verilog/nice_row_buf.sv
// NICE row buffer

module nice_row_buf #(
  parameter int XLEN    = nice_pkg::xlen,
  parameter int ROW_LEN = nice_pkg::row_len_dflt
) (
  input  logic                              nice_clk,
  input  logic                              nice_rst_n,
  // read port for sbuf write data
  input  logic [nice_pkg::rowbuf_idx_w-1:0] rd_idx,
  output logic [XLEN-1:0]                   rd_data,
  // beats from the memory agent
  nice_beat_if.sink                         beat
);

  logic [XLEN-1:0] entry [nice_pkg::rowbuf_dp];
  logic            wr_lbuf;
  logic            wr_rowsum;

  // the whole row has to fit in the buffer
  if (ROW_LEN > nice_pkg::rowbuf_dp) begin : g_row_len_chk
    $error("nice_row_buf: ROW_LEN exceeds row buffer depth");
  end

  assign wr_lbuf   = beat.valid & (beat.op == nice_pkg::op_lbuf);
  assign wr_rowsum = beat.valid & (beat.op == nice_pkg::op_rowsum);

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  // lbuf overwrites, rowsum builds column sums
  // contents survive from one instruction to the next
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      for (int i = 0; i < nice_pkg::rowbuf_dp; i++) begin
        entry[i] <= '0;
      end
    end else if (wr_lbuf) begin
      entry[beat.idx] <= beat.data;
    end else if (wr_rowsum) begin
      // wraps modulo 2^XLEN
      entry[beat.idx] <= entry[beat.idx] + beat.data;
    end
  end

  // combinational read, stable during sbuf since sbuf beats write nothing
  assign rd_data = entry[rd_idx];

endmodule

//--- verilog/nice_rowsum_acc.sv
// NICE rowsum accumulator

module nice_rowsum_acc #(
  parameter int XLEN    = nice_pkg::xlen,
  parameter int ROW_LEN = nice_pkg::row_len_dflt
) (
  input  logic            nice_clk,
  input  logic            nice_rst_n,
  // running row sum, final one cycle after the last beat
  output logic [XLEN-1:0] sum,
  nice_beat_if.sink       beat
);

  logic acc_en;

  // an empty row has no sum
  if (ROW_LEN < 1) begin : g_row_len_chk
    $error("nice_rowsum_acc: ROW_LEN must be at least 1");
  end

  assign acc_en = beat.valid & (beat.op == nice_pkg::op_rowsum);

  // first word restarts the sum, the rest add on
  // lbuf and sbuf beats leave the sum alone
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      sum <= '0;
    end else if (acc_en) begin
      if (beat.idx == '0)
        sum <= beat.data;
      else
        sum <= sum + beat.data;
    end
  end

endmodule

//--- verilog/nice_core.sv
// NICE coprocessor core

module nice_core #(
  parameter int XLEN    = nice_pkg::xlen,
  parameter int ROW_LEN = nice_pkg::row_len_dflt
) (
  // system
  input  logic            nice_clk,
  input  logic            nice_rst_n,
  output logic            nice_active,
  output logic            nice_mem_holdup,
  // host request
  input  logic            nice_req_valid,
  output logic            nice_req_ready,
  input  logic [XLEN-1:0] nice_req_inst,
  input  logic [XLEN-1:0] nice_req_rs1,
  input  logic [XLEN-1:0] nice_req_rs2,
  // host response
  output logic            nice_rsp_valid,
  input  logic            nice_rsp_ready,
  output logic [XLEN-1:0] nice_rsp_rdat,
  output logic            nice_rsp_err,
  // ICB command
  output logic            nice_icb_cmd_valid,
  input  logic            nice_icb_cmd_ready,
  output logic [XLEN-1:0] nice_icb_cmd_addr,
  output logic            nice_icb_cmd_read,
  output logic [XLEN-1:0] nice_icb_cmd_wdata,
  output logic [1:0]      nice_icb_cmd_size,
  // ICB response
  input  logic            nice_icb_rsp_valid,
  output logic            nice_icb_rsp_ready,
  input  logic [XLEN-1:0] nice_icb_rsp_rdata,
  input  logic            nice_icb_rsp_err
);

  // job handoff
  logic                              job_start;
  nice_pkg::nice_op_e                job_op;
  logic [XLEN-1:0]                   job_base;
  logic                              job_done;
  logic                              job_err;
  // sbuf read path
  logic [nice_pkg::rowbuf_idx_w-1:0] rd_idx;
  logic [XLEN-1:0]                   rd_data;
  logic [XLEN-1:0]                   rowsum_sum;

  // rs2 has no use in this instruction set
  nice_beat_if #(.XLEN(XLEN)) u_beat ();

  ////////////////////////////////////////
  // control and memory
  ////////////////////////////////////////
  nice_ctrl #(.XLEN(XLEN), .ROW_LEN(ROW_LEN)) u_ctrl (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .req_valid  (nice_req_valid),
    .req_ready  (nice_req_ready),
    .req_inst   (nice_req_inst),
    .req_rs1    (nice_req_rs1),
    .rsp_valid  (nice_rsp_valid),
    .rsp_ready  (nice_rsp_ready),
    .rsp_rdat   (nice_rsp_rdat),
    .rsp_err    (nice_rsp_err),
    .active     (nice_active),
    .mem_holdup (nice_mem_holdup),
    .job_start  (job_start),
    .job_op     (job_op),
    .job_base   (job_base),
    .job_done   (job_done),
    .job_err    (job_err),
    .rowsum_sum (rowsum_sum)
  );

  nice_mem_agent #(.XLEN(XLEN), .ROW_LEN(ROW_LEN)) u_mem_agent (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .job_start     (job_start),
    .job_op        (job_op),
    .job_base      (job_base),
    .job_done      (job_done),
    .job_err       (job_err),
    .icb_cmd_valid (nice_icb_cmd_valid),
    .icb_cmd_ready (nice_icb_cmd_ready),
    .icb_cmd_addr  (nice_icb_cmd_addr),
    .icb_cmd_read  (nice_icb_cmd_read),
    .icb_cmd_wdata (nice_icb_cmd_wdata),
    .icb_cmd_size  (nice_icb_cmd_size),
    .icb_rsp_valid (nice_icb_rsp_valid),
    .icb_rsp_ready (nice_icb_rsp_ready),
    .icb_rsp_rdata (nice_icb_rsp_rdata),
    .icb_rsp_err   (nice_icb_rsp_err),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .beat          (u_beat.src)
  );

  ////////////////////////////////////////
  // beat consumers, side by side
  ////////////////////////////////////////
  nice_row_buf #(.XLEN(XLEN), .ROW_LEN(ROW_LEN)) u_row_buf (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .rd_idx     (rd_idx),
    .rd_data    (rd_data),
    .beat       (u_beat.sink)
  );

  nice_rowsum_acc #(.XLEN(XLEN), .ROW_LEN(ROW_LEN)) u_rowsum_acc (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .sum        (rowsum_sum),
    .beat       (u_beat.sink)
  );

endmodule

//--- dv/nice_core_assert.sv
// NICE core handshake assertions

module nice_core_assert #(
  parameter int XLEN = nice_pkg::xlen
) (
  input logic            nice_clk,
  input logic            nice_rst_n,
  input logic            nice_req_ready,
  input logic            nice_mem_holdup,
  input logic            nice_rsp_valid,
  input logic            nice_rsp_ready,
  input logic            nice_icb_cmd_valid,
  input logic            nice_icb_cmd_ready,
  input logic [XLEN-1:0] nice_icb_cmd_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // host side
  ////////////////////////////////////////
  // response stays up until the host takes it
  rsp_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_rsp_valid && !nice_rsp_ready |=> nice_rsp_valid)
    else $error("nice_rsp_valid dropped before it was taken");

  // holdup and the blocked request both last until the response is taken
  holdup_blocks_req: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_mem_holdup && !(nice_rsp_valid && nice_rsp_ready) |=>
      nice_mem_holdup && !nice_req_ready)
    else $error("nice_mem_holdup dropped or nice_req_ready rose before the response");

  ////////////////////////////////////////
  // ICB side
  ////////////////////////////////////////
  // stalled command keeps valid and address
  cmd_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_icb_cmd_valid && !nice_icb_cmd_ready |=>
      nice_icb_cmd_valid && $stable(nice_icb_cmd_addr))
    else $error("ICB command changed before it was taken");

endmodule

bind nice_core nice_core_assert #(.XLEN(XLEN)) u_nice_core_assert (
  .nice_clk           (nice_clk),
  .nice_rst_n         (nice_rst_n),
  .nice_req_ready     (nice_req_ready),
  .nice_mem_holdup    (nice_mem_holdup),
  .nice_rsp_valid     (nice_rsp_valid),
  .nice_rsp_ready     (nice_rsp_ready),
  .nice_icb_cmd_valid (nice_icb_cmd_valid),
  .nice_icb_cmd_ready (nice_icb_cmd_ready),
  .nice_icb_cmd_addr  (nice_icb_cmd_addr)
);

//--- dv/tb_nice_core.sv
// NICE core testbench

module tb_nice_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN    = nice_pkg::xlen;
  localparam int ROW_LEN = nice_pkg::row_len_dflt;
  // instructions over the run and worst cycles spent per word
  localparam int num_tests      = 12;
  localparam int max_stall      = 8;
  localparam int timeout_cycles = num_tests * ROW_LEN * max_stall * 2 + 300;
  // word index that answers every access with an ICB error
  localparam logic [7:0] err_word = 8'h60;

  logic            nice_clk;
  logic            nice_rst_n;
  logic            nice_active;
  logic            nice_mem_holdup;
  logic            nice_req_valid;
  logic            nice_req_ready;
  logic [XLEN-1:0] nice_req_inst;
  logic [XLEN-1:0] nice_req_rs1;
  logic [XLEN-1:0] nice_req_rs2;
  logic            nice_rsp_valid;
  logic            nice_rsp_ready;
  logic [XLEN-1:0] nice_rsp_rdat;
  logic            nice_rsp_err;
  logic            nice_icb_cmd_valid;
  logic            nice_icb_cmd_ready;
  logic [XLEN-1:0] nice_icb_cmd_addr;
  logic            nice_icb_cmd_read;
  logic [XLEN-1:0] nice_icb_cmd_wdata;
  logic [1:0]      nice_icb_cmd_size;
  logic            nice_icb_rsp_valid;
  logic            nice_icb_rsp_ready;
  logic [XLEN-1:0] nice_icb_rsp_rdata;
  logic            nice_icb_rsp_err;

  // memory model state and the expected row buffer
  logic [XLEN-1:0] mem [256];
  logic [XLEN-1:0] exp_buf [ROW_LEN];
  logic [31:0]     lcg_state = 32'd14644;
  logic            stall_en;
  logic            exp_read;
  logic [XLEN-1:0] exp_addr;
  int              cmd_total;
  int              mem_cyc;
  int              clk_cnt;
  int              err_cnt;
  // clock count when the latest ICB response went out
  int              last_rsp_clk;
  // pending ICB responses, oldest first
  logic [XLEN-1:0] rsp_data_q [$];
  logic            rsp_err_q [$];
  int              rsp_due_q [$];

  nice_core #(.XLEN(XLEN), .ROW_LEN(ROW_LEN)) u_nice_core (.*);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic fail_stop(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    if (got !== exp)
      fail_stop($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;
  endfunction

  // R type custom-3 word, register fields are arbitrary
  function automatic logic [31:0] make_inst(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd11, 5'd10, f3, 5'd12, nice_pkg::opcode_custom3};
  endfunction

  function automatic int word_at(input logic [XLEN-1:0] base, input int k);
    return ((base >> 2) + k) % 256;
  endfunction

  function automatic logic is_err_addr(input logic [XLEN-1:0] addr);
    return addr[9:2] == err_word;
  endfunction

  ////////////////////////////////////////
  // clock, watchdog, memory
  ////////////////////////////////////////
  initial begin
    nice_clk = 1'b0;
    forever #2 nice_clk = ~nice_clk;
  end

  always @(posedge nice_clk) begin
    clk_cnt++;
    if (clk_cnt > timeout_cycles)
      fail_stop($sformatf("run did not finish within %0d cycles", timeout_cycles));
  end

  // responses leave first so a command never answers in its own cycle
  always @(negedge nice_clk) begin
    mem_cyc++;
    nice_icb_rsp_valid = 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= mem_cyc) begin
      nice_icb_rsp_valid = 1'b1;
      nice_icb_rsp_rdata = rsp_data_q.pop_front();
      nice_icb_rsp_err   = rsp_err_q.pop_front();
      void'(rsp_due_q.pop_front());
      last_rsp_clk = clk_cnt;
    end
    // the core never refuses a response
    check("nice_icb_rsp_ready", nice_icb_rsp_ready, 1'b1);
    nice_icb_cmd_ready = stall_en ? ((lcg_next() % 4) != 0) : 1'b1;
    // valid and ready both hold to the next rising edge
    if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
      check("nice_icb_cmd_addr", nice_icb_cmd_addr, exp_addr);
      check("nice_icb_cmd_read", nice_icb_cmd_read, exp_read);
      check("nice_icb_cmd_size", nice_icb_cmd_size, nice_pkg::icb_size_word);
      exp_addr += nice_pkg::word_stride;
      cmd_total++;
      if (!nice_icb_cmd_read && !is_err_addr(nice_icb_cmd_addr))
        mem[nice_icb_cmd_addr[9:2]] = nice_icb_cmd_wdata;
      rsp_data_q.push_back(mem[nice_icb_cmd_addr[9:2]]);
      rsp_err_q.push_back(is_err_addr(nice_icb_cmd_addr));
      rsp_due_q.push_back(mem_cyc + 1 + (stall_en ? int'(lcg_next() % 3) : 0));
    end
  end

  ////////////////////////////////////////
  // instruction and test tasks
  ////////////////////////////////////////
  // starts and ends on a falling edge, hold keeps rsp_ready low a while
  task automatic run_instr(input logic [31:0] inst, input logic [XLEN-1:0] rs1,
                           input logic rd, input logic [XLEN-1:0] exp_rdat,
                           input logic exp_err, input int hold);
    int base_cnt;
    base_cnt       = cmd_total;
    exp_addr       = rs1;
    exp_read       = rd;
    nice_req_valid = 1'b1;
    nice_req_inst  = inst;
    nice_req_rs1   = rs1;
    nice_req_rs2   = lcg_next();
    while (!nice_req_ready) @(negedge nice_clk);
    @(negedge nice_clk);
    nice_req_valid = 1'b0;
    while (!nice_rsp_valid) @(negedge nice_clk);
    // response comes one cycle after the last ICB response
    check("nice_rsp_valid latency", clk_cnt - last_rsp_clk, 1);
    check("nice_mem_holdup", nice_mem_holdup, 1'b1);
    repeat (hold) begin
      @(negedge nice_clk);
      check("nice_rsp_valid", nice_rsp_valid, 1'b1);
      check("nice_req_ready", nice_req_ready, 1'b0);
      check("nice_mem_holdup", nice_mem_holdup, 1'b1);
    end
    check("nice_rsp_rdat", nice_rsp_rdat, exp_rdat);
    check("nice_rsp_err", nice_rsp_err, exp_err);
    check("icb command count", cmd_total - base_cnt, ROW_LEN);
    nice_rsp_ready = 1'b1;
    @(negedge nice_clk);
    nice_rsp_ready = 1'b0;
    check("nice_rsp_valid", nice_rsp_valid, 1'b0);
    check("nice_mem_holdup", nice_mem_holdup, 1'b0);
  endtask

  task automatic idle_and_unknown();
    int base_cnt;
    check("nice_icb_cmd_valid", nice_icb_cmd_valid, 1'b0);
    check("nice_rsp_valid", nice_rsp_valid, 1'b0);
    check("nice_mem_holdup", nice_mem_holdup, 1'b0);
    check("nice_active", nice_active, 1'b0);
    base_cnt = cmd_total;
    // add x12, x10, x11 is not ours
    nice_req_valid = 1'b1;
    nice_req_inst  = 32'h00b50633;
    #1;
    check("nice_active", nice_active, 1'b1);
    check("nice_req_ready", nice_req_ready, 1'b1);
    @(negedge nice_clk);
    nice_req_valid = 1'b0;
    repeat (12) begin
      @(negedge nice_clk);
      check("nice_rsp_valid", nice_rsp_valid, 1'b0);
      check("nice_mem_holdup", nice_mem_holdup, 1'b0);
    end
    check("icb command count", cmd_total - base_cnt, 0);
  endtask

  task automatic copy_row(input logic [XLEN-1:0] src, input logic [XLEN-1:0] dst,
                          input int hold);
    for (int k = 0; k < ROW_LEN; k++)
      exp_buf[k] = mem[word_at(src, k)];
    run_instr(make_inst(nice_pkg::funct7_lbuf, nice_pkg::funct3_buf), src, 1'b1, '0, 1'b0,
              hold);
    run_instr(make_inst(nice_pkg::funct7_sbuf, nice_pkg::funct3_buf), dst, 1'b0, '0, 1'b0,
              hold);
    for (int k = 0; k < ROW_LEN; k++)
      check("copied word", mem[word_at(dst, k)], mem[word_at(src, k)]);
  endtask

  // rowsum adds each word into its column of the buffer too
  task automatic sum_row(input logic [XLEN-1:0] src, input logic [XLEN-1:0] dst,
                         input int hold);
    logic [XLEN-1:0] total;
    total = '0;
    for (int k = 0; k < ROW_LEN; k++) begin
      total      += mem[word_at(src, k)];
      exp_buf[k] += mem[word_at(src, k)];
    end
    run_instr(make_inst(nice_pkg::funct7_rowsum, nice_pkg::funct3_rowsum), src, 1'b1,
              total, 1'b0, hold);
    run_instr(make_inst(nice_pkg::funct7_sbuf, nice_pkg::funct3_buf), dst, 1'b0, '0, 1'b0,
              hold);
    for (int k = 0; k < ROW_LEN; k++)
      check("column sum word", mem[word_at(dst, k)], exp_buf[k]);
  endtask

  task automatic mem_error();
    logic [XLEN-1:0] total;
    total = '0;
    // row starts one word below the marked word
    for (int k = 0; k < ROW_LEN; k++)
      total += mem[word_at({err_word - 8'd1, 2'b00}, k)];
    run_instr(make_inst(nice_pkg::funct7_rowsum, nice_pkg::funct3_rowsum),
              {err_word - 8'd1, 2'b00}, 1'b1, total, 1'b1, 0);
    run_instr(make_inst(nice_pkg::funct7_lbuf, nice_pkg::funct3_buf), 32'h040, 1'b1, '0,
              1'b0, 0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    nice_rst_n         = 1'b0;
    nice_req_valid     = 1'b0;
    nice_req_inst      = '0;
    nice_req_rs1       = '0;
    nice_req_rs2       = '0;
    nice_rsp_ready     = 1'b0;
    nice_icb_cmd_ready = 1'b0;
    nice_icb_rsp_valid = 1'b0;
    nice_icb_rsp_rdata = '0;
    nice_icb_rsp_err   = 1'b0;
    stall_en     = 1'b0;
    exp_read     = 1'b1;
    exp_addr     = '0;
    cmd_total    = 0;
    mem_cyc      = 0;
    clk_cnt      = 0;
    err_cnt      = 0;
    last_rsp_clk = 0;
    // fill mixes every address bit into the word
    for (int i = 0; i < 256; i++)
      mem[i] = (i + 1) * 32'h9e3779b9 ^ (i << 20);
    for (int k = 0; k < ROW_LEN; k++)
      exp_buf[k] = '0;
    repeat (4) @(negedge nice_clk);
    nice_rst_n = 1'b1;
    idle_and_unknown();
    copy_row(32'h040, 32'h100, 0);
    sum_row(32'h080, 32'h140, 0);
    // memory stalls and a slow host
    stall_en = 1'b1;
    copy_row(32'h0c0, 32'h200, 5);
    sum_row(32'h240, 32'h300, 5);
    mem_error();
    if (err_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_stop("checks failed before the end of the run");
    end
  end

endmodule

//--- nice_core.f
verilog/nice_pkg.sv
verilog/nice_beat_if.sv
verilog/nice_ctrl.sv
verilog/nice_mem_agent.sv
verilog/nice_row_buf.sv
verilog/nice_rowsum_acc.sv
verilog/nice_core.sv
dv/nice_core_assert.sv
dv/tb_nice_core.sv

//--- Bender.yml
package:
  name: nice_core

sources:
  # RTL in compile order
  - files:
      - verilog/nice_pkg.sv
      - verilog/nice_beat_if.sv
      - verilog/nice_ctrl.sv
      - verilog/nice_mem_agent.sv
      - verilog/nice_row_buf.sv
      - verilog/nice_rowsum_acc.sv
      - verilog/nice_core.sv
  # testbench and bound assertions
  - target: test
    files:
      - dv/nice_core_assert.sv
      - dv/tb_nice_core.sv
